//--- core_pkg.sv
// Settings bus widths, register map, readback indices, compat number, control word type
package core_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////////////////////////////////////////

   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   // Misc register block, offsets 0 and 5 left unused
   localparam logic [SET_AW-1:0] SR_MISC    = 8'd0;
   localparam logic [SET_AW-1:0] OFS_SERDES = 8'd1;
   localparam logic [SET_AW-1:0] OFS_ADC    = 8'd2;
   localparam logic [SET_AW-1:0] OFS_LED_SW = 8'd3;
   localparam logic [SET_AW-1:0] OFS_PHY    = 8'd4;
   localparam logic [SET_AW-1:0] OFS_LED_SRC = 8'd6;

   // Time block
   localparam logic [SET_AW-1:0] SR_TIME64   = 8'd10;
   localparam logic [SET_AW-1:0] OFS_TIME_HI = 8'd0;
   localparam logic [SET_AW-1:0] OFS_TIME_LO = 8'd1;

   // LEDs 1 to 4 start under hardware control
   localparam logic [7:0] LED_RESET_SRC = 8'h1E;

   ////////////////////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////////////////////

   // Major in the upper half, minor in the lower half
   localparam logic [SET_DW-1:0] COMPAT_NUM = {16'd10, 16'd0};

   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_STATUS  = 4'd13;

   // Control stream word, seen as a command header or as write payload
   typedef union packed {
      struct packed {
         logic       is_read;
         logic [6:0] rsvd_hi;
         logic [7:0] seq;
         logic [7:0] rsvd_lo;
         logic [7:0] addr;
      } hdr;
      logic [31:0] payload;
   } ctl_word_u;

endpackage

//--- ctrl_word_engine.sv
// Control word engine: two-word write commands, readback requests, response pulse
`timescale 1ns/1ps

module ctrl_word_engine (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  core_pkg::ctl_word_u        ctl_word_i,
   input  logic                       ctl_valid_i,
   input  logic [63:0]                vita_time_i,
   input  logic [3:0]                 status_i,
   output logic                       ctl_ready_o,
   output logic                       eng_req_o,
   output logic [core_pkg::SET_AW-1:0] eng_addr_o,
   output logic [core_pkg::SET_DW-1:0] eng_data_o,
   output logic                       rsp_valid_o,
   output logic [7:0]                 rsp_seq_o,
   output logic [core_pkg::SET_DW-1:0] rsp_data_o
);
   import core_pkg::*;

   localparam logic ST_HDR = 1'b0;
   localparam logic ST_PAY = 1'b1;

   logic              state;
   logic              pay_gap;
   logic              hdr_fire;
   logic [SET_AW-1:0] wr_addr;
   logic [3:0]        rb_idx;
   logic [SET_DW-1:0] rb_word;

   // One idle cycle after each payload keeps engine requests apart
   assign ctl_ready_o = ~pay_gap;

   assign hdr_fire = ctl_valid_i & ctl_ready_o & (state == ST_HDR);

   // Write goes to the arbiter in the same cycle the payload transfers
   assign eng_req_o  = ctl_valid_i & ctl_ready_o & (state == ST_PAY);
   assign eng_addr_o = wr_addr;
   assign eng_data_o = ctl_word_i.payload;

   ////////////////////////////////////////////////////////////////////////////
   // Readback table
   ////////////////////////////////////////////////////////////////////////////

   assign rb_idx = ctl_word_i.hdr.addr[3:0];

   always_comb begin
      case (rb_idx)
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_STATUS:  rb_word = {18'b0, status_i, 10'b0};
         default:    rb_word = '1;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Command parser
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state       <= ST_HDR;
         pay_gap     <= 1'b0;
         rsp_valid_o <= 1'b0;
      end else begin
         pay_gap     <= eng_req_o;
         rsp_valid_o <= hdr_fire & ctl_word_i.hdr.is_read;
         if (hdr_fire && !ctl_word_i.hdr.is_read)
            state <= ST_PAY;
         else if (eng_req_o)
            state <= ST_HDR;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (hdr_fire) begin
         wr_addr    <= ctl_word_i.hdr.addr;
         rsp_seq_o  <= ctl_word_i.hdr.seq;
         rsp_data_o <= rb_word;
      end
   end

endmodule

//--- misc_settings.sv
// Misc setting registers, LED source mixer, PHY reset output
`timescale 1ns/1ps

module misc_settings #(
   parameter logic [core_pkg::SET_AW-1:0] BASE = core_pkg::SR_MISC
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       set_stb_i,
   input  logic [core_pkg::SET_AW-1:0] set_addr_i,
   input  logic [core_pkg::SET_DW-1:0] set_data_i,
   input  logic                       run_tx_i,
   input  logic                       run_rx_i,
   input  logic                       clk_status_i,
   input  logic                       link_good_i,
   output logic [7:0]                 leds_o,
   output logic [3:0]                 serdes_ctl_o,
   output logic [3:0]                 adc_ctl_o,
   output logic                       phy_resetn_o
);
   import core_pkg::*;

   localparam logic [SET_AW-1:0] A_SERDES  = BASE + OFS_SERDES;
   localparam logic [SET_AW-1:0] A_ADC     = BASE + OFS_ADC;
   localparam logic [SET_AW-1:0] A_LED_SW  = BASE + OFS_LED_SW;
   localparam logic [SET_AW-1:0] A_PHY     = BASE + OFS_PHY;
   localparam logic [SET_AW-1:0] A_LED_SRC = BASE + OFS_LED_SRC;

   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;
   logic       phy_reset;

   ////////////////////////////////////////////////////////////////////////////
   // Address matched registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         serdes_ctl_o <= '0;
         adc_ctl_o    <= '0;
         led_sw       <= '0;
         phy_reset    <= 1'b0;
         led_src      <= LED_RESET_SRC;
      end else if (set_stb_i) begin
         case (set_addr_i)
            A_SERDES:  serdes_ctl_o <= set_data_i[3:0];
            A_ADC:     adc_ctl_o    <= set_data_i[3:0];
            A_LED_SW:  led_sw       <= set_data_i[7:0];
            A_PHY:     phy_reset    <= set_data_i[0];
            A_LED_SRC: led_src      <= set_data_i[7:0];
            default:   ;
         endcase
      end
   end

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////////////////////
   // LEDs
   ////////////////////////////////////////////////////////////////////////////

   // Hardware status word, bit 0 has no source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_good_i, 1'b0};

   // Per bit select, 1 takes hardware and 0 takes software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_u2_ctrl \
   -f src.f -o sim_u2_ctrl > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_u2_ctrl > sim.log 2>&1
grep -q "^PASS: all tests$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- settings_arbiter.sv
// Priority arbiter for the shared settings bus with a one-entry host hold
`timescale 1ns/1ps

module settings_arbiter (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       eng_req_i,
   input  logic [core_pkg::SET_AW-1:0] eng_addr_i,
   input  logic [core_pkg::SET_DW-1:0] eng_data_i,
   input  logic                       host_stb_i,
   input  logic [core_pkg::SET_AW-1:0] host_addr_i,
   input  logic [core_pkg::SET_DW-1:0] host_data_i,
   output logic                       host_blocked_o,
   output logic                       set_stb_o,
   output logic [core_pkg::SET_AW-1:0] set_addr_o,
   output logic [core_pkg::SET_DW-1:0] set_data_o
);
   import core_pkg::*;

   logic              hold_vld;
   logic [SET_AW-1:0] hold_addr;
   logic [SET_DW-1:0] hold_data;
   logic              host_pend;
   logic [SET_AW-1:0] host_addr;
   logic [SET_DW-1:0] host_data;

   // A held write always goes before any new host strobe
   assign host_pend = host_stb_i | hold_vld;
   assign host_addr = hold_vld ? hold_addr : host_addr_i;
   assign host_data = hold_vld ? hold_data : host_data_i;

   assign host_blocked_o = hold_vld;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_stb_o <= 1'b0;
         hold_vld  <= 1'b0;
      end else begin
         set_stb_o <= eng_req_i | host_pend;
         // Engine has priority, host waits one cycle
         hold_vld  <= eng_req_i & host_pend;
      end
   end

   // Bus payload and hold contents
   always_ff @(posedge dsp_clk) begin
      if (eng_req_i) begin
         set_addr_o <= eng_addr_i;
         set_data_o <= eng_data_i;
         hold_addr  <= host_addr;
         hold_data  <= host_data;
      end else begin
         set_addr_o <= host_addr;
         set_data_o <= host_data;
      end
   end

endmodule

//--- src.f
core_pkg.sv
settings_arbiter.sv
ctrl_word_engine.sv
misc_settings.sv
vita_time_counter.sv
u2_ctrl_top.sv
u2_ctrl_props.sv
tb_u2_ctrl.sv

//--- tb_u2_ctrl.sv
// Testbench for the settings bus core: stimulus table, LFSR data, output checks, timeout
`timescale 1ns/1ps

module tb_u2_ctrl;
   import core_pkg::*;

   localparam int NUM_ROWS   = 20;
   localparam int MAX_CYCLES = 8 * NUM_ROWS + 40;

   // Fixed status inputs, and the LED and status words they give
   localparam bit RUN_TX  = 1'b1;
   localparam bit RUN_RX  = 1'b0;
   localparam bit CLK_OK  = 1'b1;
   localparam bit LINK_OK = 1'b1;
   localparam bit BUTTON  = 1'b0;
   localparam logic [7:0]  LED_HW = {3'b000, RUN_TX, RUN_RX, CLK_OK, LINK_OK, 1'b0};
   localparam logic [31:0] STATUS_WORD = {18'b0, BUTTON, CLK_OK, LINK_OK, 1'b0, 10'b0};

   typedef enum int {HOST_WR, CTL_WR, CTL_RD, BOTH_WR} kind_e;
   typedef enum int {NONE, LEDS, SERDES, ADC, PHYN, RSP, TIME_GE} sig_e;

   typedef struct packed {
      kind_e       kind;
      logic [7:0]  addr;
      logic [31:0] data;
      sig_e        sig;
      logic [31:0] exp;
      bit          rnd;
   } row_t;

   logic        dsp_clk;
   logic        por_rst;
   logic        host_stb;
   logic [7:0]  host_addr;
   logic [31:0] host_data;
   logic        host_blocked;
   logic [31:0] ctl_word;
   logic        ctl_valid;
   logic        ctl_ready;
   logic        rsp_valid;
   logic [7:0]  rsp_seq;
   logic [31:0] rsp_data;
   logic [7:0]  leds;
   logic [3:0]  serdes;
   logic [3:0]  adc;
   logic        phy_resetn;

   row_t        rows [NUM_ROWS];
   logic [15:0] lfsr;
   logic [7:0]  model_sw;
   logic [7:0]  model_src;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   u2_ctrl_top DUT (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .host_stb_i(host_stb), .host_addr_i(host_addr), .host_data_i(host_data),
      .host_blocked_o(host_blocked),
      .ctl_word_i(ctl_word), .ctl_valid_i(ctl_valid), .ctl_ready_o(ctl_ready),
      .rsp_valid_o(rsp_valid), .rsp_seq_o(rsp_seq), .rsp_data_o(rsp_data),
      .run_tx_i(RUN_TX), .run_rx_i(RUN_RX), .clk_status_i(CLK_OK),
      .link_good_i(LINK_OK), .button_i(BUTTON),
      .leds_o(leds), .serdes_ctl_o(serdes), .adc_ctl_o(adc), .phy_resetn_o(phy_resetn));

   bind u2_ctrl_top u2_ctrl_props props (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .host_stb_i(host_stb_i),
      .host_blocked_o(host_blocked_o), .ctl_ready_o(ctl_ready_o),
      .eng_req(eng_req), .set_stb(set_stb));

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Run stopped at the cycle limit, checks %0d, errors %0d", checks, errors);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_byte(output logic [7:0] v);
      v = '0;
      repeat (8) begin
         lfsr = lfsr_next(lfsr);
         v = {v[6:0], lfsr[0]};
      end
   endtask

   // 1 in the source mask picks the hardware bit
   function automatic logic [7:0] led_mix(input logic [7:0] src, input logic [7:0] sw);
      logic [7:0] m;
      for (int b = 0; b < 8; b++)
         m[b] = src[b] ? LED_HW[b] : sw[b];
      return m;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input bit at_least);
      checks++;
      if (at_least ? (got < exp) : (got !== exp)) begin
         errors++;
         $display("FAILED %s: got 0x%08h, expected %s0x%08h", name, got,
                  at_least ? "at least " : "", exp);
      end
   endtask

   task automatic check_output(input sig_e s, input logic [31:0] exp);
      case (s)
         LEDS:    check_value("leds_o", {24'b0, leds}, exp, 1'b0);
         SERDES:  check_value("serdes_ctl_o", {28'b0, serdes}, exp, 1'b0);
         ADC:     check_value("adc_ctl_o", {28'b0, adc}, exp, 1'b0);
         PHYN:    check_value("phy_resetn_o", {31'b0, phy_resetn}, exp, 1'b0);
         RSP:     check_value("rsp_data_o", rsp_data, exp, 1'b0);
         TIME_GE: check_value("rsp_data_o", rsp_data, exp, 1'b1);
         default: ;
      endcase
   endtask

   task automatic wait_cycle;
      @(posedge dsp_clk);
      #2;
   endtask

   task automatic host_write(input logic [7:0] a, input logic [31:0] d);
      host_addr = a;
      host_data = d;
      host_stb  = 1'b1;
      wait_cycle;
      host_stb  = 1'b0;
   endtask

   // Holds valid until an edge sees ready, returns 2 ns after that edge
   task automatic send_word(input logic [31:0] w);
      logic rdy;
      ctl_word  = w;
      ctl_valid = 1'b1;
      do begin
         @(negedge dsp_clk);
         rdy = ctl_ready;
         @(posedge dsp_clk);
      end while (!rdy);
      #2;
      ctl_valid = 1'b0;
   endtask

   task automatic set_row(input int i, input kind_e k, input logic [7:0] a,
                          input logic [31:0] d, input sig_e s, input logic [31:0] e,
                          input bit rnd);
      rows[i] = '{k, a, d, s, e, rnd};
   endtask

   task automatic apply_row(input int i);
      row_t        r;
      logic [7:0]  rb;
      logic [7:0]  seq;
      logic [31:0] hdr;
      r   = rows[i];
      seq = 8'h40 + i[7:0];
      if (r.rnd) begin
         random_byte(rb);
         r.data = {24'b0, rb};
      end
      // Model keeps the final LED register values
      if (r.kind != CTL_RD && r.addr == SR_MISC + OFS_LED_SW)
         model_sw = r.data[7:0];
      if (r.kind != CTL_RD && r.addr == SR_MISC + OFS_LED_SRC)
         model_src = r.data[7:0];
      if (r.sig == LEDS)
         r.exp = {24'b0, led_mix(model_src, model_sw)};
      hdr = {r.kind == CTL_RD, 7'b0, seq, 8'b0, r.addr};
      case (r.kind)
         HOST_WR: begin
            host_write(r.addr, r.data);
            wait_cycle;
            @(negedge dsp_clk);
            check_output(r.sig, r.exp);
         end
         CTL_WR: begin
            send_word(hdr);
            send_word(r.data);
            @(negedge dsp_clk);
            check_value("ctl_ready_o", {31'b0, ctl_ready}, 32'd0, 1'b0);
            wait_cycle;
            @(negedge dsp_clk);
            check_value("ctl_ready_o", {31'b0, ctl_ready}, 32'd1, 1'b0);
            check_output(r.sig, r.exp);
         end
         CTL_RD: begin
            send_word(hdr);
            @(negedge dsp_clk);
            check_value("rsp_valid_o", {31'b0, rsp_valid}, 32'd1, 1'b0);
            check_value("rsp_seq_o", {24'b0, rsp_seq}, {24'b0, seq}, 1'b0);
            check_output(r.sig, r.exp);
            wait_cycle;
            @(negedge dsp_clk);
            check_value("rsp_valid_o", {31'b0, rsp_valid}, 32'd0, 1'b0);
         end
         default: begin
            send_word(hdr);
            // Payload and host strobe together, control carries the inverted nibble
            ctl_word  = r.data ^ 32'hF;
            ctl_valid = 1'b1;
            host_addr = r.addr;
            host_data = r.data;
            host_stb  = 1'b1;
            wait_cycle;
            ctl_valid = 1'b0;
            host_stb  = 1'b0;
            @(negedge dsp_clk);
            check_value("host_blocked_o", {31'b0, host_blocked}, 32'd1, 1'b0);
            wait_cycle;
            @(negedge dsp_clk);
            check_value("host_blocked_o", {31'b0, host_blocked}, 32'd0, 1'b0);
            check_output(r.sig, {28'b0, r.data[3:0] ^ 4'hF});
            wait_cycle;
            @(negedge dsp_clk);
            check_output(r.sig, r.exp);
         end
      endcase
      wait_cycle;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      por_rst   = 1'b1;
      host_stb  = 1'b0;
      host_addr = '0;
      host_data = '0;
      ctl_word  = '0;
      ctl_valid = 1'b0;
      lfsr      = 16'd39;
      model_sw  = 8'h00;
      model_src = 8'h1E;

      set_row(0,  HOST_WR, SR_MISC + OFS_SERDES,  32'h5,  SERDES, 32'h5, 1'b0);
      set_row(1,  HOST_WR, SR_MISC + OFS_ADC,     32'hA,  ADC,    32'hA, 1'b0);
      set_row(2,  HOST_WR, SR_MISC + OFS_PHY,     32'h1,  PHYN,   32'h0, 1'b0);
      set_row(3,  HOST_WR, SR_MISC + OFS_LED_SW,  32'h0,  LEDS,   32'h0, 1'b1);
      set_row(4,  HOST_WR, SR_MISC + OFS_LED_SRC, 32'h0F, LEDS,   32'h0, 1'b0);
      set_row(5,  HOST_WR, SR_MISC + OFS_LED_SW,  32'h0,  LEDS,   32'h0, 1'b1);
      set_row(6,  CTL_WR,  SR_MISC + OFS_SERDES,  32'h3,  SERDES, 32'h3, 1'b0);
      set_row(7,  CTL_WR,  SR_MISC + OFS_ADC,     32'h6,  ADC,    32'h6, 1'b0);
      set_row(8,  CTL_WR,  SR_MISC + OFS_PHY,     32'h0,  PHYN,   32'h1, 1'b0);
      set_row(9,  CTL_WR,  SR_MISC + OFS_LED_SW,  32'h0,  LEDS,   32'h0, 1'b1);
      set_row(10, CTL_WR,  SR_MISC + OFS_LED_SRC, 32'hC3, LEDS,   32'h0, 1'b0);
      set_row(11, BOTH_WR, SR_MISC + OFS_SERDES,  32'h9,  SERDES, 32'h9, 1'b0);
      set_row(12, BOTH_WR, SR_MISC + OFS_ADC,     32'hC,  ADC,    32'hC, 1'b0);
      set_row(13, CTL_RD,  8'd12, 32'h0, RSP, 32'h000A_0000, 1'b0);
      set_row(14, CTL_RD,  8'd5,  32'h0, RSP, 32'hFFFF_FFFF, 1'b0);
      set_row(15, CTL_RD,  8'd13, 32'h0, RSP, STATUS_WORD,   1'b0);
      set_row(16, HOST_WR, SR_TIME64 + OFS_TIME_HI, 32'h12, NONE, 32'h0, 1'b0);
      set_row(17, CTL_WR,  SR_TIME64 + OFS_TIME_LO, 32'h1000, NONE, 32'h0, 1'b0);
      set_row(18, CTL_RD,  8'd10, 32'h0, RSP,     32'h12, 1'b0);
      set_row(19, CTL_RD,  8'd11, 32'h0, TIME_GE, 32'h1000, 1'b0);

      repeat (8) @(posedge dsp_clk);
      #2;
      por_rst = 1'b0;

      // Reset values
      @(negedge dsp_clk);
      check_output(LEDS, {24'b0, led_mix(8'h1E, 8'h00)});
      check_output(SERDES, 32'h0);
      check_output(ADC, 32'h0);
      check_output(PHYN, 32'h1);
      check_value("ctl_ready_o", {31'b0, ctl_ready}, 32'd1, 1'b0);
      check_value("rsp_valid_o", {31'b0, rsp_valid}, 32'd0, 1'b0);
      check_value("host_blocked_o", {31'b0, host_blocked}, 32'd0, 1'b0);
      wait_cycle;

      for (int i = 0; i < NUM_ROWS; i++)
         apply_row(i);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- u2_ctrl_props.sv
// Concurrent assertions on arbiter and control stream timing of the top level
`timescale 1ns/1ps

module u2_ctrl_props (
   input logic dsp_clk,
   input logic por_rst,
   input logic host_stb_i,
   input logic host_blocked_o,
   input logic ctl_ready_o,
   input logic eng_req,
   input logic set_stb
);

   // Engine requests are always separated by an idle cycle
   a_eng_gap: assert property (@(posedge dsp_clk) disable iff (por_rst)
      eng_req |=> !eng_req) else $error("engine requested in back to back cycles");

   a_host_held: assert property (@(posedge dsp_clk) disable iff (por_rst)
      eng_req && host_stb_i |=> host_blocked_o) else $error("contested host write not held");

   // Held write goes out right after the engine write
   a_hold_len: assert property (@(posedge dsp_clk) disable iff (por_rst)
      host_blocked_o |-> set_stb ##1 (set_stb && !host_blocked_o))
      else $error("held host write not issued in the next cycle");

   a_ready_gap: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !ctl_ready_o |=> ctl_ready_o) else $error("ctl_ready_o low for more than one cycle");

   a_req_to_bus: assert property (@(posedge dsp_clk) disable iff (por_rst)
      eng_req || host_stb_i |=> set_stb) else $error("request did not reach the bus");

endmodule

//--- u2_ctrl_top.sv
// Top level of the settings bus core: arbiter, control engine, misc registers, time counter
`timescale 1ns/1ps

module u2_ctrl_top #(
   parameter logic [core_pkg::SET_AW-1:0] MISC_BASE = core_pkg::SR_MISC,
   parameter logic [core_pkg::SET_AW-1:0] TIME_BASE = core_pkg::SR_TIME64
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   // Host write port
   input  logic                       host_stb_i,
   input  logic [core_pkg::SET_AW-1:0] host_addr_i,
   input  logic [core_pkg::SET_DW-1:0] host_data_i,
   output logic                       host_blocked_o,
   // Control stream and response
   input  core_pkg::ctl_word_u        ctl_word_i,
   input  logic                       ctl_valid_i,
   output logic                       ctl_ready_o,
   output logic                       rsp_valid_o,
   output logic [7:0]                 rsp_seq_o,
   output logic [core_pkg::SET_DW-1:0] rsp_data_o,
   // Status inputs
   input  logic                       run_tx_i,
   input  logic                       run_rx_i,
   input  logic                       clk_status_i,
   input  logic                       link_good_i,
   input  logic                       button_i,
   // Control outputs
   output logic [7:0]                 leds_o,
   output logic [3:0]                 serdes_ctl_o,
   output logic [3:0]                 adc_ctl_o,
   output logic                       phy_resetn_o
);
   import core_pkg::*;

   logic              eng_req;
   logic [SET_AW-1:0] eng_addr;
   logic [SET_DW-1:0] eng_data;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data;
   logic [63:0]       vita_time;
   logic [3:0]        status;

   assign status = {button_i, clk_status_i, link_good_i, 1'b0};

   ////////////////////////////////////////////////////////////////////////////
   // Bus masters
   ////////////////////////////////////////////////////////////////////////////

   ctrl_word_engine ctrl_word_engine (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .ctl_word_i(ctl_word_i), .ctl_valid_i(ctl_valid_i), .ctl_ready_o(ctl_ready_o),
      .vita_time_i(vita_time), .status_i(status),
      .eng_req_o(eng_req), .eng_addr_o(eng_addr), .eng_data_o(eng_data),
      .rsp_valid_o(rsp_valid_o), .rsp_seq_o(rsp_seq_o), .rsp_data_o(rsp_data_o));

   settings_arbiter settings_arbiter (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .eng_req_i(eng_req), .eng_addr_i(eng_addr), .eng_data_i(eng_data),
      .host_stb_i(host_stb_i), .host_addr_i(host_addr_i), .host_data_i(host_data_i),
      .host_blocked_o(host_blocked_o),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////////////////////////////////////////////////////////////
   // Bus slaves
   ////////////////////////////////////////////////////////////////////////////

   misc_settings #(.BASE(MISC_BASE)) misc_settings (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i),
      .clk_status_i(clk_status_i), .link_good_i(link_good_i),
      .leds_o(leds_o), .serdes_ctl_o(serdes_ctl_o), .adc_ctl_o(adc_ctl_o),
      .phy_resetn_o(phy_resetn_o));

   vita_time_counter #(.BASE(TIME_BASE)) vita_time_counter (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_o(vita_time));

endmodule

//--- vita_time_counter.sv
// Free running 64-bit time counter with a settable value
`timescale 1ns/1ps

module vita_time_counter #(
   parameter logic [core_pkg::SET_AW-1:0] BASE = core_pkg::SR_TIME64
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       set_stb_i,
   input  logic [core_pkg::SET_AW-1:0] set_addr_i,
   input  logic [core_pkg::SET_DW-1:0] set_data_i,
   output logic [63:0]                vita_time_o
);
   import core_pkg::*;

   localparam logic [SET_AW-1:0] A_HI = BASE + OFS_TIME_HI;
   localparam logic [SET_AW-1:0] A_LO = BASE + OFS_TIME_LO;

   logic [31:0] pending_hi;
   logic        load_time;

   assign load_time = set_stb_i && (set_addr_i == A_LO);

   // High word waits here until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         pending_hi <= '0;
      else if (set_stb_i && (set_addr_i == A_HI))
         pending_hi <= set_data_i;
   end

   // Load replaces the increment for that cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         vita_time_o <= '0;
      else if (load_time)
         vita_time_o <= {pending_hi, set_data_i};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

endmodule
